//--- src/cpu_pkg.sv
package cpu_pkg;

    // Widths
    // --------------------------------------
    typedef logic [7:0]  byte_t;                 // Data byte
    typedef logic [15:0] addr_t;                 // Bus address

    // P register bit positions
    // --------------------------------------
    localparam int FLAG_N = 7;                   // Negative
    localparam int FLAG_V = 6;                   // Overflow
    localparam int FLAG_D = 3;                   // Decimal, stored only
    localparam int FLAG_I = 2;                   // Interrupt mask, stored only
    localparam int FLAG_Z = 1;                   // Zero
    localparam int FLAG_C = 0;                   // Carry

    localparam addr_t RESET_VECTOR = 16'hFFFC;   // Low byte of start address
    localparam byte_t P_RESET      = 8'h00;      // Flags after reset

    // Microstates
    // --------------------------------------
    typedef enum logic [3:0] {
        S_FETCH,                                 // Opcode arrives on din
        S_ZP,                                    // Zero page address arrives
        S_ABS,                                   // Low address byte arrives
        S_ABS2,                                  // High address byte arrives
        S_LAT,                                   // JMP target latch
        S_EXEC,                                  // Operand arrives, writeback
        S_REL,                                   // Branch offset arrives
        S_REL1,                                  // Page cross penalty
        S_REL2,                                  // Taken branch, fetch target
        S_RST,                                   // Vector low address out
        S_RST2,                                  // Vector high address out
        S_RST3                                   // Vector complete
    } ustate_e;

    typedef enum logic [2:0] {
        AM_IMP,                                  // Implied, also NOP
        AM_IMM,                                  // #imm
        AM_ZP,                                   // $zz
        AM_ABS,                                  // $hhll
        AM_REL,                                  // Conditional branch
        AM_JMP                                   // JMP $hhll
    } amode_e;

    typedef enum logic [3:0] {
        ALU_ORA, ALU_AND, ALU_EOR, ALU_ADC,
        ALU_PASS,                                // Loads, stores, transfers
        ALU_CMP, ALU_SBC,
        ALU_FLAGOP,                              // CLC/SEC/CLI/SEI/CLV/CLD/SED
        ALU_DEC, ALU_INC
    } alu_op_e;

    typedef enum logic [1:0] {
        R_A, R_X, R_Y,
        R_DIN                                    // Memory data instead of a register
    } reg_sel_e;

    // Decoded instruction controls
    typedef struct packed {
        amode_e   amode;
        alu_op_e  alu_op;
        reg_sel_e ra;                            // Destination and operand A
        reg_sel_e rb;                            // Operand B
        logic     wr;                            // Write result to ra
        logic     fw;                            // Write flags
        logic     store;                         // Memory write of result
    } cpu_ctrl_t;

endpackage

//--- src/opcode_decode.sv
`timescale 1ns/100ps

module opcode_decode (
    input  cpu_pkg::byte_t    opcode,
    output cpu_pkg::cpu_ctrl_t ctrl
);
    import cpu_pkg::*;

    logic [2:0] aaa;                             // Operation field
    logic [2:0] bbb;                             // Mode field
    logic [1:0] cc;                              // Group field
    amode_e     mem_mode;                        // Mode of groups 00 and 10
    alu_op_e    acc_op;                          // Accumulator group operation

    assign aaa = opcode[7:5];
    assign bbb = opcode[4:2];
    assign cc  = opcode[1:0];

    always_comb begin
        case (bbb)
            3'b000:  mem_mode = AM_IMM;          // LDX/LDY/CPX/CPY #
            3'b001:  mem_mode = AM_ZP;
            3'b011:  mem_mode = AM_ABS;
            default: mem_mode = AM_IMP;
        endcase
    end

    always_comb begin
        case (aaa)
            3'b000:  acc_op = ALU_ORA;
            3'b001:  acc_op = ALU_AND;
            3'b010:  acc_op = ALU_EOR;
            3'b011:  acc_op = ALU_ADC;
            3'b110:  acc_op = ALU_CMP;
            3'b111:  acc_op = ALU_SBC;
            default: acc_op = ALU_PASS;          // STA, LDA
        endcase
    end

    always_comb begin
        ctrl = '{amode: AM_IMP, alu_op: ALU_PASS, ra: R_A, rb: R_DIN,
                 wr: 1'b0, fw: 1'b0, store: 1'b0};    // Two cycle NOP
        if (cc == 2'b01) begin
            // Accumulator group
            case (bbb)
                3'b001:  ctrl.amode = AM_ZP;
                3'b010:  ctrl.amode = (aaa == 3'b100) ? AM_IMP : AM_IMM;  // No STA #
                3'b011:  ctrl.amode = AM_ABS;
                default: ctrl.amode = AM_IMP;
            endcase
            if (ctrl.amode != AM_IMP) begin
                ctrl.alu_op = acc_op;
                ctrl.rb     = (aaa == 3'b100) ? R_A : R_DIN;      // STA sends A
                ctrl.wr     = (aaa != 3'b100) && (aaa != 3'b110); // Not STA, CMP
                ctrl.fw     = (aaa != 3'b100);
                ctrl.store  = (aaa == 3'b100);
            end
        end else begin
            casez (opcode)
                8'hE8, 8'hC8: begin              // INX, INY
                    ctrl.alu_op = ALU_INC;
                    ctrl.ra     = opcode[5] ? R_X : R_Y;
                    ctrl.rb     = ctrl.ra;
                    {ctrl.wr, ctrl.fw} = 2'b11;
                end
                8'hCA, 8'h88: begin              // DEX, DEY
                    ctrl.alu_op = ALU_DEC;
                    ctrl.ra     = opcode[1] ? R_X : R_Y;
                    ctrl.rb     = ctrl.ra;
                    {ctrl.wr, ctrl.fw} = 2'b11;
                end
                8'hAA, 8'hA8: begin              // TAX, TAY
                    ctrl.ra = opcode[1] ? R_X : R_Y;
                    ctrl.rb = R_A;
                    {ctrl.wr, ctrl.fw} = 2'b11;
                end
                8'h8A, 8'h98: begin              // TXA, TYA
                    ctrl.rb = opcode[1] ? R_X : R_Y;
                    {ctrl.wr, ctrl.fw} = 2'b11;
                end
                8'b???_110_00: begin             // Flag set and clear
                    ctrl.alu_op = ALU_FLAGOP;
                    ctrl.fw     = 1'b1;
                end
                8'b???_100_00: ctrl.amode = AM_REL;   // Bxx
                8'h4C:         ctrl.amode = AM_JMP;
                8'b101_000_?0, 8'b101_001_?0, 8'b101_011_?0: begin   // LDX, LDY
                    ctrl.amode = mem_mode;
                    ctrl.ra    = opcode[1] ? R_X : R_Y;
                    {ctrl.wr, ctrl.fw} = 2'b11;
                end
                8'b100_001_?0, 8'b100_011_?0: begin  // STX, STY
                    ctrl.amode = mem_mode;
                    ctrl.rb    = opcode[1] ? R_X : R_Y;
                    ctrl.store = 1'b1;
                end
                8'b11?_000_00, 8'b11?_001_00, 8'b11?_011_00: begin  // CPX, CPY
                    ctrl.amode  = mem_mode;
                    ctrl.alu_op = ALU_CMP;
                    ctrl.ra     = opcode[5] ? R_X : R_Y;
                    ctrl.fw     = 1'b1;
                end
                default: ;                       // Unimplemented, NOP
            endcase
        end
    end

endmodule

//--- src/cpu_alu.sv
`timescale 1ns/100ps

module cpu_alu (
    input  cpu_pkg::byte_t   a_op,
    input  cpu_pkg::byte_t   b_op,
    input  cpu_pkg::alu_op_e op,
    input  cpu_pkg::byte_t   p,
    input  logic [2:0]       sel,                // opcode[7:5]
    output cpu_pkg::byte_t   res,
    output cpu_pkg::byte_t   new_p
);
    import cpu_pkg::*;

    logic [8:0] sum;                             // Adder with carry out
    byte_t      b_in;                            // B, inverted for subtract
    logic       c_in;                            // Adder carry in

    // Shared adder
    // --------------------------------------
    always_comb begin
        b_in = ((op == ALU_SBC) || (op == ALU_CMP)) ? ~b_op : b_op;
        c_in = (op == ALU_CMP) ? 1'b1 : p[FLAG_C];   // Compare ignores C
        sum  = {1'b0, a_op} + {1'b0, b_in} + {8'h00, c_in};
    end

    // Result and flags
    // --------------------------------------
    always_comb begin
        res   = a_op;
        new_p = p;
        case (op)
            ALU_ORA: res = a_op | b_op;
            ALU_AND: res = a_op & b_op;
            ALU_EOR: res = a_op ^ b_op;
            ALU_ADC, ALU_SBC: begin
                res           = sum[7:0];
                new_p[FLAG_C] = sum[8];
                // Same sign in, other sign out
                new_p[FLAG_V] = (a_op[7] == b_in[7]) && (sum[7] != a_op[7]);
            end
            ALU_CMP: begin
                res           = sum[7:0];        // Difference, flags only
                new_p[FLAG_C] = sum[8];          // No borrow, a >= b
            end
            ALU_PASS: res = b_op;
            ALU_INC:  res = a_op + 8'd1;
            ALU_DEC:  res = a_op - 8'd1;
            ALU_FLAGOP: begin
                case (sel[2:1])
                    2'b00:   new_p[FLAG_C] = sel[0];   // CLC, SEC
                    2'b01:   new_p[FLAG_I] = sel[0];   // CLI, SEI
                    2'b10:   new_p[FLAG_V] = 1'b0;     // CLV
                    default: new_p[FLAG_D] = sel[0];   // CLD, SED
                endcase
            end
            default: ;
        endcase
        if (op != ALU_FLAGOP) begin
            new_p[FLAG_N] = res[7];
            new_p[FLAG_Z] = (res == 8'h00);
        end
    end

endmodule

//--- src/register_file.sv
`timescale 1ns/100ps

module register_file (
    input  logic               CLK,
    input  logic               RESET,
    input  cpu_pkg::cpu_ctrl_t ctrl,
    input  logic               exec,
    input  cpu_pkg::byte_t     din,
    input  cpu_pkg::byte_t     res,
    input  cpu_pkg::byte_t     new_p,
    output cpu_pkg::byte_t     a_op,
    output cpu_pkg::byte_t     b_op,
    output cpu_pkg::byte_t     p
);
    import cpu_pkg::*;

    byte_t a_reg;                                // Accumulator
    byte_t x_reg;
    byte_t y_reg;
    byte_t p_reg;                                // Status

    // Register or memory data by select
    function automatic byte_t pick(input reg_sel_e s, input byte_t a_val,
                                   input byte_t x_val, input byte_t y_val,
                                   input byte_t d_val);
        case (s)
            R_A:     return a_val;
            R_X:     return x_val;
            R_Y:     return y_val;
            default: return d_val;
        endcase
    endfunction

    assign a_op = pick(ctrl.ra, a_reg, x_reg, y_reg, din);
    assign b_op = pick(ctrl.rb, a_reg, x_reg, y_reg, din);
    assign p    = p_reg;

    // Writeback at end of EXEC
    always_ff @(posedge CLK) begin
        if (RESET) begin
            a_reg <= 8'h00;
            x_reg <= 8'h00;
            y_reg <= 8'h00;
            p_reg <= P_RESET;
        end else if (exec) begin
            if (ctrl.wr) begin
                case (ctrl.ra)
                    R_A:     a_reg <= res;
                    R_X:     x_reg <= res;
                    R_Y:     y_reg <= res;
                    default: ;                   // No register behind din
                endcase
            end
            if (ctrl.fw) p_reg <= new_p;
        end
    end

endmodule

//--- src/cpu_sequencer.sv
`timescale 1ns/100ps

module cpu_sequencer (
    input  logic               CLK,
    input  logic               RESET,
    input  cpu_pkg::byte_t     din,
    input  cpu_pkg::cpu_ctrl_t ctrl,
    input  cpu_pkg::byte_t     p,
    input  cpu_pkg::byte_t     res,
    output cpu_pkg::byte_t     opcode,
    output logic               exec,
    output cpu_pkg::addr_t     addr,
    output cpu_pkg::addr_t     eawr,
    output cpu_pkg::byte_t     dout,
    output logic               wreq
);
    import cpu_pkg::*;

    ustate_e state;
    addr_t   pc;                                 // Next byte of the instruction stream
    addr_t   ea;                                 // Effective address for stores
    byte_t   tr;                                 // Low address byte
    byte_t   opcode_q;                           // Current instruction
    logic    ea_sel;                             // 1 = addr from ea_next, 0 = pc
    addr_t   ea_next;                            // Address formed from din
    addr_t   pc_inc;
    addr_t   target;                             // Branch destination
    logic    flag;                               // Flag tested by branch
    logic    taken;

    // Addressing
    // --------------------------------------
    // Memory answers one cycle late, so each cycle puts out the address
    // whose data the next state consumes
    assign pc_inc  = pc + 16'd1;
    assign target  = pc + {{8{din[7]}}, din};    // Signed offset
    assign ea_next = (state == S_ZP) ? {8'h00, din} : {din, tr};
    assign ea_sel  = (state == S_ZP) || (state == S_ABS2) ||
                     (state == S_LAT) || (state == S_RST3);
    assign addr    = ea_sel ? ea_next : pc;
    assign eawr    = ea;

    // New opcode decoded in the cycle it arrives
    assign opcode = (state == S_FETCH) ? din : opcode_q;
    assign exec   = (state == S_EXEC);

    // Branch condition, opcode[7:6] picks N, V, C or Z
    always_comb begin
        case (opcode_q[7:6])
            2'b00:   flag = p[FLAG_N];
            2'b01:   flag = p[FLAG_V];
            2'b10:   flag = p[FLAG_C];
            default: flag = p[FLAG_Z];
        endcase
        taken = (flag == opcode_q[5]);
    end

    // Microstate machine
    // --------------------------------------
    always_ff @(posedge CLK) begin
        if (RESET) begin
            state    <= S_RST;
            wreq     <= 1'b0;
            pc       <= RESET_VECTOR;
            opcode_q <= 8'h00;
        end else begin
            case (state)
                S_FETCH: begin
                    opcode_q <= din;
                    wreq     <= 1'b0;            // Ends a store strobe
                    if (ctrl.amode != AM_IMP) pc <= pc_inc;   // Skip operand byte
                    case (ctrl.amode)
                        AM_ZP:           state <= S_ZP;
                        AM_ABS, AM_JMP:  state <= S_ABS;
                        AM_REL:          state <= S_REL;
                        default:         state <= S_EXEC;     // Implied, immediate
                    endcase
                end
                S_ZP: begin
                    ea    <= ea_next;
                    state <= S_EXEC;
                end
                S_ABS: begin
                    tr    <= din;                // Low byte
                    pc    <= pc_inc;
                    state <= (ctrl.amode == AM_JMP) ? S_LAT : S_ABS2;
                end
                S_ABS2: begin
                    ea    <= ea_next;
                    state <= S_EXEC;
                end
                S_LAT: begin
                    pc    <= ea_next + 16'd1;    // Target already on addr
                    state <= S_FETCH;
                end
                S_EXEC: begin
                    pc <= pc_inc;                // Next opcode is on addr
                    if (ctrl.store) begin
                        dout <= res;
                        wreq <= 1'b1;
                    end
                    state <= S_FETCH;
                end
                S_REL: begin
                    if (taken) begin
                        pc    <= target;
                        state <= (target[15:8] != pc[15:8]) ? S_REL1 : S_REL2;
                    end else begin
                        pc    <= pc_inc;
                        state <= S_FETCH;
                    end
                end
                S_REL1: state <= S_REL2;         // Page cross
                S_REL2: begin
                    pc    <= pc_inc;
                    state <= S_FETCH;
                end
                S_RST: begin
                    pc    <= pc_inc;             // To $FFFD
                    state <= S_RST2;
                end
                S_RST2: begin
                    tr    <= din;                // Vector low byte
                    state <= S_RST3;
                end
                S_RST3: begin
                    pc    <= ea_next + 16'd1;
                    state <= S_FETCH;
                end
                default: state <= S_FETCH;
            endcase
        end
    end

endmodule

//--- src/cpu_top.sv
`timescale 1ns/100ps

module cpu_top (
    input  logic           CLK,
    input  logic           RESET,
    output cpu_pkg::addr_t addr,                 // Read address
    input  cpu_pkg::byte_t din,                  // Read data, one cycle late
    output cpu_pkg::byte_t dout,
    output cpu_pkg::addr_t eawr,                 // Write address
    output logic           wreq                  // Write strobe
);
    import cpu_pkg::*;

    byte_t     opcode;
    cpu_ctrl_t ctrl;
    logic      exec;
    byte_t     a_op;
    byte_t     b_op;
    byte_t     p;
    byte_t     res;
    byte_t     new_p;

    cpu_sequencer u_seq (
        .CLK    (CLK),
        .RESET  (RESET),
        .din    (din),
        .ctrl   (ctrl),
        .p      (p),
        .res    (res),
        .opcode (opcode),
        .exec   (exec),
        .addr   (addr),
        .eawr   (eawr),
        .dout   (dout),
        .wreq   (wreq)
    );

    opcode_decode u_dec (.opcode(opcode), .ctrl(ctrl));

    cpu_alu u_alu (
        .a_op(a_op), .b_op(b_op), .op(ctrl.alu_op), .p(p),
        .sel(opcode[7:5]), .res(res), .new_p(new_p)
    );

    register_file u_regs (
        .CLK(CLK), .RESET(RESET), .ctrl(ctrl), .exec(exec), .din(din),
        .res(res), .new_p(new_p), .a_op(a_op), .b_op(b_op), .p(p)
    );

endmodule

//--- verif/cpu_assert.sv
`timescale 1ns/100ps

module cpu_assert (
    input logic           CLK,
    input logic           RESET,
    input logic           wreq,
    input cpu_pkg::addr_t eawr
);
    import cpu_pkg::*;

    int fails = 0;                               // Failed assertion count

    // Bus strobe rules
    // ----------------------------------------
    // No write in any cycle that reset is held
    no_write_in_reset: assert property (@(posedge CLK) RESET |-> (wreq !== 1'b1))
        else begin
            $error("wreq high during reset");
            fails++;
        end

    single_cycle_strobe: assert property (@(posedge CLK) disable iff (RESET)
        wreq |=> !wreq)
        else begin
            $error("wreq high on two consecutive cycles");
            fails++;
        end

    stable_write_addr: assert property (@(posedge CLK) disable iff (RESET)
        wreq |-> $stable(eawr))
        else begin
            $error("eawr changed while wreq high");
            fails++;
        end

endmodule

bind cpu_top cpu_assert u_assert (.CLK(CLK), .RESET(RESET), .wreq(wreq), .eawr(eawr));

//--- verif/cpu_tb.sv
`timescale 1ns/100ps

module cpu_tb;
    import cpu_pkg::*;

    localparam int NROWS = 24;
    localparam int LIMIT = NROWS * 40 + 100;     // Cycle budget for the whole run
    localparam logic [1:0] K_ACC = 2'd0;         // Accumulator op, immediate
    localparam logic [1:0] K_MEM = 2'd1;         // ZP and absolute moves
    localparam logic [1:0] K_BR  = 2'd2;         // CMP then branch
    localparam logic [1:0] K_FLG = 2'd3;         // SEC, ADC then BCS

    typedef struct packed {
        logic [1:0] kind;
        byte_t      op;                          // Opcode under test
        byte_t      a;
        byte_t      b;
        logic       cin;
        addr_t      vec;                         // Program start
    } row_t;

    typedef struct packed {
        addr_t wa;
        byte_t wd;
    } wr_t;

    logic  CLK = 1'b0;
    logic  RESET = 1'b1;
    byte_t din = 8'h00;
    addr_t addr;
    addr_t eawr;
    byte_t dout;
    logic  wreq;

    byte_t  mem [0:65535];
    row_t   rows [NROWS];
    wr_t    exp_q[$];                            // Stores the program should make
    wr_t    log_q[$];                            // Stores seen on the bus
    addr_t  wp;                                  // Program build pointer
    int     exp_cycles = 0;                      // Reset release to marker strobe
    integer seed = 32'h5719a8d6;
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;

    cpu_top DUT (.CLK(CLK), .RESET(RESET), .addr(addr), .din(din), .dout(dout),
                 .eawr(eawr), .wreq(wreq));

    always #5 CLK = ~CLK;

    // Memory model
    // ----------------------------------------
    always @(posedge CLK) begin
        din <= #1 mem[addr];                     // Registered read
        if (wreq) begin
            mem[eawr] <= dout;
            log_q.push_back({eawr, dout});
        end
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("Timeout: run exceeded %0d cycles without finishing", LIMIT);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    // One instruction of len bytes, cyc cycles if it runs
    task automatic put_insn(input int cyc, input int len, input byte_t b0,
                            input byte_t b1, input byte_t b2);
        byte_t bytes [3];
        bytes = '{b0, b1, b2};
        for (int k = 0; k < len; k++) begin
            mem[wp] = bytes[k];
            wp++;
        end
        exp_cycles += cyc;
    endtask

    // LDA #$A5, STA $FF, JMP to itself
    task automatic put_marker();
        addr_t here;
        here = wp + 16'd4;
        put_insn(2, 2, 8'hA9, 8'hA5, 8'h00);
        put_insn(3, 2, 8'h85, 8'hFF, 8'h00);
        put_insn(1, 3, 8'h4C, here[7:0], here[15:8]);   // Strobe seen in its fetch
    endtask

    // Documented accumulator rules, decimal ignored
    function automatic byte_t acc_result(input byte_t op, input byte_t a,
                                         input byte_t b, input logic c);
        case (op)
            8'h09:   return a | b;
            8'h29:   return a & b;
            8'h49:   return a ^ b;
            8'h69:   return a + b + c;
            8'hE9:   return a - b - (c ? 8'd0 : 8'd1);   // Borrow is !C
            8'hA9:   return b;
            default: return a;                   // CMP leaves A alone
        endcase
    endfunction

    task automatic build_program(input row_t r);
        addr_t nxt;
        addr_t dest;
        addr_t mark;
        logic  tk;
        int    br_cyc;
        wp = r.vec;
        exp_q.delete();
        exp_cycles = 3;                          // RST, RST2, RST3
        case (r.kind)
            K_ACC: begin
                put_insn(2, 2, 8'hA9, r.a, 8'h00);                   // LDA #a
                put_insn(2, 1, r.cin ? 8'h38 : 8'h18, 8'h00, 8'h00); // SEC or CLC
                put_insn(2, 2, r.op, r.b, 8'h00);
                put_insn(3, 2, 8'h85, 8'h40, 8'h00);                 // STA $40
                exp_q.push_back({16'h0040, acc_result(r.op, r.a, r.b, r.cin)});
            end
            K_MEM: begin
                put_insn(2, 2, 8'hA2, r.a, 8'h00);       // LDX #a
                put_insn(3, 2, 8'h86, 8'h10, 8'h00);     // STX $10
                put_insn(4, 3, 8'hAC, 8'h10, 8'h00);     // LDY $0010
                put_insn(2, 1, 8'hC8, 8'h00, 8'h00);     // INY
                put_insn(4, 3, 8'h8C, 8'h34, 8'h12);     // STY $1234
                put_insn(2, 1, 8'h98, 8'h00, 8'h00);     // TYA
                put_insn(2, 1, 8'hCA, 8'h00, 8'h00);     // DEX
                put_insn(3, 2, 8'h85, 8'h42, 8'h00);     // STA $42
                put_insn(3, 2, 8'h86, 8'h43, 8'h00);     // STX $43
                exp_q.push_back({16'h0010, r.a});
                exp_q.push_back({16'h1234, byte_t'(r.a + 8'd1)});
                exp_q.push_back({16'h0042, byte_t'(r.a + 8'd1)});
                exp_q.push_back({16'h0043, byte_t'(r.a - 8'd1)});
            end
            default: begin
                if (r.kind == K_FLG)
                    tk = ({1'b0, r.a} + {1'b0, r.b} + 9'd1) > 9'd255;
                else if (r.op == 8'hF0)
                    tk = (r.a == r.b);
                else if (r.op == 8'hB0)
                    tk = (r.a >= r.b);
                else
                    tk = byte_t'(r.a - r.b) >= 8'h80;             // BMI
                if (r.kind == K_FLG)
                    put_insn(2, 1, 8'h38, 8'h00, 8'h00);         // SEC
                put_insn(2, 2, 8'hA9, r.a, 8'h00);
                put_insn(2, 2, (r.kind == K_FLG) ? 8'h69 : 8'hC9, r.b, 8'h00);
                nxt  = wp + 16'd2;                               // Fall-through start
                dest = nxt + 16'd7;                              // Taken path
                if (!tk)
                    br_cyc = 2;
                else if (dest[15:8] != nxt[15:8])
                    br_cyc = 4;                                  // Page cross
                else
                    br_cyc = 3;
                put_insn(br_cyc, 2, r.op, 8'd7, 8'h00);          // Skip fall-through
                mark = wp + 16'd11;                              // Marker address
                put_insn(tk ? 0 : 2, 2, 8'hA9, 8'h02, 8'h00);
                put_insn(tk ? 0 : 3, 2, 8'h85, 8'h41, 8'h00);
                put_insn(tk ? 0 : 3, 3, 8'h4C, mark[7:0], mark[15:8]);
                put_insn(tk ? 2 : 0, 2, 8'hA9, 8'h01, 8'h00);
                put_insn(tk ? 3 : 0, 2, 8'h85, 8'h41, 8'h00);
                exp_q.push_back({16'h0041, tk ? 8'h01 : 8'h02});
            end
        endcase
        put_marker();
        exp_q.push_back({16'h00FF, 8'hA5});
        mem[16'hFFFC] = r.vec[7:0];
        mem[16'hFFFD] = r.vec[15:8];
    endtask

    task automatic run_row(input row_t r);
        logic seen;
        int   ncyc;
        seen = 1'b0;
        ncyc = 0;
        @(posedge CLK);
        #1 RESET = 1'b1;
        build_program(r);
        repeat (5) @(posedge CLK);
        log_q.delete();
        #1 RESET = 1'b0;
        while (!seen) begin
            @(negedge CLK);
            ncyc++;                              // Cycles since reset release
            seen = wreq && (eawr == 16'h00FF);
        end
        @(posedge CLK);
        #2;
        check_value("cycles", ncyc, exp_cycles);
        check_value("write count", log_q.size(), exp_q.size());
        foreach (exp_q[i]) begin
            if (i < log_q.size()) begin
                check_value("eawr", log_q[i].wa, exp_q[i].wa);
                check_value("dout", log_q[i].wd, exp_q[i].wd);
            end
            check_value("mem", mem[exp_q[i].wa], exp_q[i].wd);
        end
    endtask

    // Program table
    // ----------------------------------------
    initial begin
        integer rnd;
        for (int i = 0; i < 65536; i++)
            mem[i] = byte_t'(i[7:0] ^ i[15:8] ^ 8'h5A);  // Address-dependent fill
        rows[0]  = '{K_ACC, 8'h09, 8'h5A, 8'h0F, 1'b0, 16'h0200};
        rows[1]  = '{K_ACC, 8'h29, 8'hF0, 8'h3C, 1'b0, 16'h0300};
        rows[2]  = '{K_ACC, 8'h49, 8'hAA, 8'h55, 1'b0, 16'h0400};
        rows[3]  = '{K_ACC, 8'h69, 8'h7F, 8'h01, 1'b0, 16'h0500};
        rows[4]  = '{K_ACC, 8'h69, 8'hFF, 8'h01, 1'b1, 16'h0600};
        rows[5]  = '{K_ACC, 8'hE9, 8'h50, 8'h30, 1'b1, 16'h0700};
        rows[6]  = '{K_ACC, 8'hE9, 8'h10, 8'h20, 1'b0, 16'h0800};
        rows[7]  = '{K_ACC, 8'hC9, 8'h33, 8'h44, 1'b1, 16'h0900};
        rows[8]  = '{K_ACC, 8'hA9, 8'h12, 8'h80, 1'b0, 16'h0A00};
        rows[9]  = '{K_ACC, 8'h69, 8'h00, 8'h00, 1'b1, 16'h0B00};
        rows[10] = '{K_ACC, 8'hE9, 8'h00, 8'h00, 1'b0, 16'h0C00};
        rows[11] = '{K_MEM, 8'h00, 8'h7F, 8'h00, 1'b0, 16'h0D00};
        rows[12] = '{K_MEM, 8'h00, 8'h00, 8'h00, 1'b0, 16'h0E00};
        rows[13] = '{K_MEM, 8'h00, 8'hFF, 8'h00, 1'b0, 16'h0F00};
        rows[14] = '{K_BR,  8'hF0, 8'h44, 8'h44, 1'b0, 16'h10F4};  // Crosses page
        rows[15] = '{K_BR,  8'hF0, 8'h44, 8'h45, 1'b0, 16'h1100};
        rows[16] = '{K_BR,  8'hB0, 8'h80, 8'h7F, 1'b0, 16'h12F4};  // Crosses page
        rows[17] = '{K_BR,  8'hB0, 8'h10, 8'h20, 1'b0, 16'h1300};
        rows[18] = '{K_BR,  8'h30, 8'h10, 8'h20, 1'b0, 16'h14F4};  // Crosses page
        rows[19] = '{K_BR,  8'h30, 8'h20, 8'h10, 1'b0, 16'h1500};
        rows[20] = '{K_FLG, 8'hB0, 8'hF0, 8'h0F, 1'b0, 16'h1600};
        rows[21] = '{K_FLG, 8'hB0, 8'h10, 8'h20, 1'b0, 16'h1700};
        rows[22] = '{K_FLG, 8'hB0, 8'h00, 8'h00, 1'b0, 16'h18F3};  // Crosses page
        rows[23] = '{K_MEM, 8'h00, 8'h00, 8'h00, 1'b0, 16'h1900};
        for (int i = 9; i < NROWS; i++) begin
            if (i == 9 || i == 10 || i == 22 || i == 23) begin
                rnd = $random(seed);
                rows[i].a = rnd[7:0];
                rows[i].b = rnd[15:8];
            end
        end
        for (int i = 0; i < NROWS; i++)
            run_row(rows[i]);
        $display("Checks run: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, DUT.u_assert.fails);
        if (errors == 0 && DUT.u_assert.fails == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- tb.f
src/cpu_pkg.sv
src/opcode_decode.sv
src/cpu_alu.sv
src/register_file.sv
src/cpu_sequencer.sv
src/cpu_top.sv
verif/cpu_assert.sv
verif/cpu_tb.sv
